//--- sources.f
+incdir+bench
source/csa_calc_pkg.sv
source/csa_calc_logic.sv
source/csa_job_dispatch.sv
source/csa_result_collect.sv
source/csa_calc_array.sv
bench/csa_calc_array_tb.sv

//--- Makefile
TOP = csa_calc_array_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

//--- bench/csa_calc_model.svh
`ifndef CSA_CALC_MODEL_SVH
`define CSA_CALC_MODEL_SVH

// Rotate left by three, then XOR 0x63
function automatic logic [7:0] model_sub(input logic [7:0] b);
	logic [7:0] rot;
	rot = (b << 3) | (b >> 5);
	return rot ^ 8'h63;
endfunction

function automatic csa_state_t model_run(input csa_key_t key, input int times);
	logic [7:0] cur [6];
	logic [7:0] nxt [6];
	csa_state_t packed_state;
	int         rounds;
	cur[5] = 8'h00;
	for (int i = 0; i < 5; i++) begin
		cur[i] = key[8*i +: 8];
		cur[5] = cur[5] + cur[i];    // Checksum byte
	end
	rounds = (times == 0) ? 1 : times;
	for (int r = 0; r < rounds; r++) begin
		for (int i = 0; i < 6; i++) begin
			nxt[i] = model_sub(cur[i] ^ cur[(i + 1) % 6]) ^ 8'(r);
		end
		cur = nxt;    // All bytes update from the old state
	end
	for (int i = 0; i < 6; i++) begin
		packed_state[8*i +: 8] = cur[i];
	end
	return packed_state;
endfunction

task automatic compare_state(input string what, input csa_state_t expected,
	input csa_state_t actual);
	if (actual !== expected) begin
		errors++;
		$display("Mismatch in %s, %s: expected %h, actual %h",
			test_name, what, expected, actual);
	end
endtask

task automatic compare_result(input string what, input csa_result_t expected,
	input csa_result_t actual);
	if (actual !== expected) begin
		errors++;
		$display("Mismatch in %s, %s: expected %h, actual %h",
			test_name, what, expected, actual);
	end
endtask

task automatic compare_flag(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		errors++;
		$display("Mismatch in %s, %s: expected %b, actual %b",
			test_name, what, expected, actual);
	end
endtask

task automatic single_job();
	int waited;
	test_name = "single job";
	send_job(4'd1, '0, 1, 0, 0, waited);
	drain();
endtask

task automatic round_counts();
	int       waited;
	csa_key_t k0;
	test_name = "round counts";
	k0 = rand_key();
	send_job(4'd1, k0, 0, 0, -1, waited);
	send_job(4'd2, rand_key(), 1, 0, -1, waited);
	send_job(4'd3, rand_key(), 5, 0, -1, waited);
	send_job(4'd4, rand_key(), 100, 0, -1, waited);
	drain();
	compare_state("times 0 against one round", model_run(k0, 1), got_state[1]);
endtask

task automatic delay_gaps();
	int       waited;
	csa_key_t k;
	test_name = "delay";
	k = rand_key();
	send_job(4'd1, k, 4, 3, -1, waited);    // Needs at least 4*4+2 cycles
	send_job(4'd2, k, 4, 0, -1, waited);
	drain();
	compare_state("delay 3 against delay 0", got_state[2], got_state[1]);
endtask

task automatic parallel_engines();
	int waited;
	int taken;
	test_name = "parallelism";
	send_job(4'd1, rand_key(), 20, 0, 0, waited);
	send_job(4'd2, rand_key(), 20, 0, 1, waited);
	if (waited != 0) begin
		errors++;
		$display("Second job in %s waited %0d cycles with an engine free", test_name, waited);
	end
	compare_flag("third job stalls", 1'b0, job_ready);
	taken = rx_count;
	send_job(4'd3, rand_key(), 3, 0, -1, waited);
	if (rx_count == taken) begin
		errors++;
		$display("Third job in %s was accepted before any result was taken", test_name);
	end
	drain();
endtask

task automatic back_pressure();
	int          waited;
	csa_result_t held;
	test_name = "back-pressure";
	rx_enable = 1'b0;
	send_job(4'd1, rand_key(), 3, 0, -1, waited);
	send_job(4'd2, rand_key(), 3, 0, -1, waited);
	waited = 0;
	while (!result_valid && waited < 100) begin
		tick();
		waited++;
	end
	if (!result_valid) begin
		errors++;
		$display("No result became valid in %s", test_name);
	end
	held = result;
	repeat (20) begin
		tick();
		compare_flag("valid held", 1'b1, result_valid);
		compare_result("result held", held, result);
	end
	rx_enable = 1'b1;
	drain();
endtask

task automatic reset_mid_job();
	int waited;
	test_name = "reset";
	rx_enable = 1'b0;    // Engine 0 stays in hold with its result pending
	send_job(4'd1, rand_key(), 1, 0, -1, waited);
	send_job(4'd2, rand_key(), 100, 0, -1, waited);
	repeat (10) tick();
	compare_flag("result_valid before reset", 1'b1, result_valid);
	compare_flag("job_ready before reset", 1'b0, job_ready);
	apply_reset();
	forget_jobs();    // Jobs cut off by the reset never return
	rx_enable = 1'b1;
	compare_flag("result_valid after reset", 1'b0, result_valid);
	compare_flag("job_ready after reset", 1'b1, job_ready);
	send_job(4'd3, rand_key(), 5, 1, 0, waited);
	drain();
endtask

`endif

//--- bench/csa_calc_array_tb.sv
module csa_calc_array_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import csa_calc_pkg::*;

	// All six tests together take roughly 400 cycles
	localparam int CYCLE_LIMIT = 4000;
	localparam int DRAIN_LIMIT = 500;
	localparam int NUM_TAGS    = 16;

	logic        clk;
	logic        rst_n;
	csa_job_t    job;
	logic        job_valid;
	logic        job_ready;
	csa_result_t result;
	logic        result_valid;
	logic        result_ready;

	int         errors;
	int         cycles;
	int         rx_count;
	integer     seed;
	logic       rx_enable;    // Ready level used from the next cycle on
	string      test_name;

	// Expected results, indexed by tag
	logic       pending [NUM_TAGS];
	csa_state_t exp_state [NUM_TAGS];
	csa_state_t got_state [NUM_TAGS];
	int         exp_id [NUM_TAGS];    // Negative when any engine may run the job
	int         accept_cycle [NUM_TAGS];
	int         min_lat [NUM_TAGS];

	csa_calc_array i_csa_calc_array (
		.clk          (clk),
		.rst_n        (rst_n),
		.job          (job),
		.job_valid    (job_valid),
		.job_ready    (job_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run stopped after %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	// One clock step; outputs are sampled and inputs driven 1 ns after the edge
	task automatic tick();
		@(posedge clk);
		#1;
		result_ready = rx_enable;
		if (rst_n && result_valid && result_ready) begin
			take_result(result);    // Transfer happens on the coming edge
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) tick();
		rst_n = 1'b1;
	endtask

	task automatic send_job(input csa_tag_t t, input csa_key_t k, input int times,
		input int delay, input int id, output int waited);
		job.tag   = t;
		job.key   = k;
		job.times = csa_count_t'(times);
		job.delay = csa_count_t'(delay);
		job_valid = 1'b1;
		waited    = 0;
		while (!job_ready) begin
			tick();
			waited++;
		end
		exp_state[t]    = model_run(k, times);
		exp_id[t]       = id;
		accept_cycle[t] = cycles + 1;
		min_lat[t]      = ((times == 0) ? 1 : times) * (delay + 1) + 2;
		pending[t]      = 1'b1;
		tick();
		job_valid = 1'b0;
	endtask

	task automatic take_result(input csa_result_t r);
		csa_result_t expected;
		int          lat;
		rx_count++;
		if (!pending[r.tag]) begin
			errors++;
			$display("Result with tag %0d in %s was not expected or came twice",
				r.tag, test_name);
		end else begin
			pending[r.tag]   = 1'b0;
			got_state[r.tag] = r.state;
			lat              = cycles - accept_cycle[r.tag];
			if (exp_id[r.tag] >= 0) begin
				expected.tag   = r.tag;
				expected.id    = csa_id_t'(exp_id[r.tag]);
				expected.state = exp_state[r.tag];
				compare_result("tagged result", expected, r);
			end else begin
				compare_state("result state", exp_state[r.tag], r.state);
			end
			if (lat < min_lat[r.tag]) begin
				errors++;
				$display("Result for tag %0d in %s arrived %0d cycles after acceptance, %s %0d",
					r.tag, test_name, lat, "fewer than the rounds need:", min_lat[r.tag]);
			end
		end
	endtask

	function automatic int pending_count();
		int n;
		n = 0;
		for (int t = 0; t < NUM_TAGS; t++) begin
			if (pending[t]) n++;
		end
		return n;
	endfunction

	// Wait for every outstanding result, then let the last clear settle
	task automatic drain();
		int waited;
		waited = 0;
		while (pending_count() > 0 && waited < DRAIN_LIMIT) begin
			tick();
			waited++;
		end
		for (int t = 0; t < NUM_TAGS; t++) begin
			if (pending[t]) begin
				errors++;
				$display("No result for tag %0d in %s", t, test_name);
				pending[t] = 1'b0;
			end
		end
		repeat (2) tick();
	endtask

	task automatic forget_jobs();
		for (int t = 0; t < NUM_TAGS; t++) begin
			pending[t] = 1'b0;
		end
	endtask

	function automatic csa_key_t rand_key();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[KEY_W-1:0];
	endfunction

	`include "csa_calc_model.svh"

	initial begin
		rst_n        = 1'b0;
		job          = '0;
		job_valid    = 1'b0;
		result_ready = 1'b0;
		rx_enable    = 1'b1;
		errors       = 0;
		rx_count     = 0;
		seed         = 32'hb1ebd8b2;
		test_name    = "power-on reset";
		forget_jobs();
		apply_reset();

		single_job();
		round_counts();
		delay_gaps();
		parallel_engines();
		back_pressure();
		reset_mid_job();

		$display("Errors: %0d, results received: %0d", errors, rx_count);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- source/csa_calc_array.sv
module csa_calc_array (
	input  logic                      clk,
	input  logic                      rst_n,
	input  csa_calc_pkg::csa_job_t    job,
	input  logic                      job_valid,
	output logic                      job_ready,
	output csa_calc_pkg::csa_result_t result,
	output logic                      result_valid,
	input  logic                      result_ready
);
	import csa_calc_pkg::*;

	logic [NUM_ENGINES-1:0] start;
	logic [NUM_ENGINES-1:0] busy;
	logic [NUM_ENGINES-1:0] done;
	logic [NUM_ENGINES-1:0] clear;
	csa_job_t               engine_job;
	csa_state_t             eng_state [NUM_ENGINES];
	csa_tag_t               eng_tag [NUM_ENGINES];

	csa_job_dispatch i_csa_job_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.job        (job),
		.job_valid  (job_valid),
		.busy       (busy),
		.job_ready  (job_ready),
		.start      (start),
		.engine_job (engine_job)
	);

	for (genvar k = 0; k < NUM_ENGINES; k++) begin : g_engine
		csa_calc_logic i_csa_calc_logic (
			.clk   (clk),
			.rst_n (rst_n),
			.start (start[k]),
			.job   (engine_job),
			.clear (clear[k]),
			.inuse (busy[k]),
			.done  (done[k]),
			.state (eng_state[k]),
			.tag   (eng_tag[k])
		);
	end

	csa_result_collect i_csa_result_collect (
		.clk          (clk),
		.rst_n        (rst_n),
		.done         (done),
		.state        (eng_state),
		.tag          (eng_tag),
		.result_ready (result_ready),
		.clear        (clear),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

//--- source/csa_result_collect.sv
module csa_result_collect (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [csa_calc_pkg::NUM_ENGINES-1:0] done,
	input  csa_calc_pkg::csa_state_t             state [csa_calc_pkg::NUM_ENGINES],
	input  csa_calc_pkg::csa_tag_t               tag [csa_calc_pkg::NUM_ENGINES],
	input  logic                                 result_ready,
	output logic [csa_calc_pkg::NUM_ENGINES-1:0] clear,
	output csa_calc_pkg::csa_result_t            result,
	output logic                                 result_valid
);
	import csa_calc_pkg::*;

	logic [NUM_ENGINES-1:0] cand;
	logic                   load;
	logic                   sel_valid;
	csa_id_t                sel_id;
	csa_id_t                last_id;    // Engine served most recently

	// Engine under clear still shows done this cycle
	assign cand = done & ~clear;
	assign load = sel_valid && (!result_valid || result_ready);

	always_comb begin
		clear = '0;
		if (result_valid && result_ready) clear[result.id] = 1'b1;
	end

	// Round-robin search starting after the last served engine
	always_comb begin
		int idx;
		sel_valid = 1'b0;
		sel_id    = last_id;
		for (int i = 1; i <= NUM_ENGINES; i++) begin
			idx = (int'(last_id) + i) % NUM_ENGINES;
			if (!sel_valid && cand[idx]) begin
				sel_valid = 1'b1;
				sel_id    = csa_id_t'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			last_id      <= csa_id_t'(NUM_ENGINES - 1);    // Engine 0 goes first
		end else begin
			if (load) begin
				result_valid <= 1'b1;
				last_id      <= sel_id;
			end else if (result_ready) begin
				result_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			result.tag   <= tag[sel_id];
			result.id    <= sel_id;
			result.state <= state[sel_id];
		end
	end

	a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

//--- source/csa_job_dispatch.sv
module csa_job_dispatch (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  csa_calc_pkg::csa_job_t               job,
	input  logic                                 job_valid,
	input  logic [csa_calc_pkg::NUM_ENGINES-1:0] busy,
	output logic                                 job_ready,
	output logic [csa_calc_pkg::NUM_ENGINES-1:0] start,
	output csa_calc_pkg::csa_job_t               engine_job
);
	import csa_calc_pkg::*;

	logic [NUM_ENGINES-1:0] free;
	logic [NUM_ENGINES-1:0] pick;
	logic                   take;

	// A started engine raises inuse one cycle late, so count start as busy
	assign free      = ~(busy | start);
	assign job_ready = |free;
	assign take      = job_valid && job_ready;

	// Lowest free engine as one-hot
	always_comb begin
		pick = '0;
		for (int k = NUM_ENGINES - 1; k >= 0; k--) begin
			if (free[k]) begin
				pick    = '0;
				pick[k] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start <= '0;
		end else begin
			start <= take ? pick : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) engine_job <= job;    // Shared by all engines, only one starts
	end

	a_start_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(start));

endmodule

//--- source/csa_calc_logic.sv
module csa_calc_logic (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  csa_calc_pkg::csa_job_t   job,
	input  logic                     clear,
	output logic                     inuse,
	output logic                     done,
	output csa_calc_pkg::csa_state_t state,
	output csa_calc_pkg::csa_tag_t   tag
);
	import csa_calc_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ROUND,
		S_GAP,
		S_HOLD
	} fsm_t;

	fsm_t       fsm;
	csa_count_t round_cnt;    // Index of the next round to apply
	csa_count_t round_nxt;
	csa_count_t gap_cnt;
	csa_count_t rounds;       // Total rounds of this job
	csa_count_t delay_len;
	logic       accept;

	function automatic csa_state_t build_state(input csa_key_t key);
		csa_state_t s;
		csa_byte_t  sum;
		sum = '0;
		for (int i = 0; i < KEY_BYTES; i++) begin
			s[BYTE_W*i +: BYTE_W] = key[BYTE_W*i +: BYTE_W];
			sum = sum + key[BYTE_W*i +: BYTE_W];    // Checksum wraps mod 256
		end
		s[BYTE_W*KEY_BYTES +: BYTE_W] = sum;
		return s;
	endfunction

	function automatic csa_state_t mix_round(input csa_state_t s, input csa_count_t r);
		csa_state_t n;
		csa_byte_t  a;
		csa_byte_t  b;
		for (int i = 0; i < STATE_BYTES; i++) begin
			a = s[BYTE_W*i +: BYTE_W];
			b = s[BYTE_W*((i + 1) % STATE_BYTES) +: BYTE_W];
			n[BYTE_W*i +: BYTE_W] = csa_sbox(a ^ b) ^ r[BYTE_W-1:0];
		end
		return n;
	endfunction

	assign accept    = start && (fsm == S_IDLE);
	assign round_nxt = round_cnt + 1'b1;
	assign inuse     = (fsm != S_IDLE);
	assign done      = (fsm == S_HOLD);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fsm       <= S_IDLE;
			round_cnt <= '0;
			gap_cnt   <= '0;
		end else begin
			case (fsm)
				S_IDLE: begin
					if (accept) begin
						round_cnt <= '0;
						fsm       <= S_ROUND;
					end
				end
				S_ROUND: begin
					round_cnt <= round_nxt;
					if (delay_len != '0) begin
						gap_cnt <= 16'd1;
						fsm     <= S_GAP;
					end else if (round_nxt == rounds) begin
						fsm <= S_HOLD;
					end
				end
				S_GAP: begin
					if (gap_cnt == delay_len) begin
						fsm <= (round_cnt == rounds) ? S_HOLD : S_ROUND;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				S_HOLD: begin
					if (clear) fsm <= S_IDLE;    // Result taken by the collector
				end
				default: fsm <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			state     <= build_state(job.key);
			tag       <= job.tag;
			delay_len <= job.delay;
			rounds    <= (job.times == '0) ? 16'd1 : job.times;
		end else if (fsm == S_ROUND) begin
			state <= mix_round(state, round_cnt);
		end
	end

	a_start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !inuse);

	a_clear_when_done: assert property (@(posedge clk) disable iff (!rst_n)
		clear |-> done);

endmodule

//--- source/csa_calc_pkg.sv
package csa_calc_pkg;

	localparam int BYTE_W      = 8;
	localparam int KEY_BYTES   = 5;
	localparam int STATE_BYTES = KEY_BYTES + 1;    // Key bytes plus checksum
	localparam int KEY_W       = BYTE_W * KEY_BYTES;
	localparam int STATE_W     = BYTE_W * STATE_BYTES;
	localparam int COUNT_W     = 16;
	localparam int TAG_W       = 4;
	localparam int NUM_ENGINES = 2;
	localparam int ID_W        = $clog2(NUM_ENGINES);

	localparam logic [BYTE_W-1:0] SBOX_XOR = 8'h63;

	typedef logic [BYTE_W-1:0]  csa_byte_t;
	typedef logic [KEY_W-1:0]   csa_key_t;     // Low byte is key byte 0
	typedef logic [STATE_W-1:0] csa_state_t;
	typedef logic [COUNT_W-1:0] csa_count_t;   // Round count or gap length
	typedef logic [TAG_W-1:0]   csa_tag_t;
	typedef logic [ID_W-1:0]    csa_id_t;

	typedef struct packed {
		csa_tag_t   tag;
		csa_key_t   key;
		csa_count_t times;    // Zero runs one round
		csa_count_t delay;    // Idle cycles after each round
	} csa_job_t;

	typedef struct packed {
		csa_tag_t   tag;
		csa_id_t    id;
		csa_state_t state;
	} csa_result_t;

	// Byte substitution of the mixing round: rotate left by three, then XOR
	function automatic csa_byte_t csa_sbox(input csa_byte_t b);
		csa_byte_t rot;
		rot = {b[4:0], b[7:5]};
		return rot ^ SBOX_XOR;
	endfunction

endpackage
